/* all.f */
src/masku_cfg_pkg.sv
src/masku_seq_pkg.sv
src/masku_result_if.sv
src/masku_insn_queue.sv
src/masku_alu.sv
src/masku_issue.sv
src/masku_result_queue.sv
src/masku_top.sv
verif/masku_props.sv
verif/tb_masku.sv

/* Makefile */
# Verilator flow for the mask unit
VERILATOR ?= verilator
TOP       ?= tb_masku
RTL_TOP   ?= masku_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= All checks passed
FAIL_MSG  ?= Checks failed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early, see $(LOG)"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/tb_masku.sv */
////////////////////////////////////////////////////////////
// Mask unit testbench
// Table-driven merges with a lane model and reference merge
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_masku;
  import masku_cfg_pkg::*;
  import masku_seq_pkg::*;

  localparam int unsigned NrLanes  = 2;
  localparam int unsigned BeatBits = NrLanes * Elen;
  localparam int unsigned NrTests  = 6;
  localparam int unsigned ClkHalf  = 50;

  // One table row of stimulus
  typedef struct packed {
    vid_t               id;
    vlen_t              vl;
    logic [VdWidth-1:0] vd;
    logic               vm;
    // Percent of cycles a lane withholds gnt
    logic [7:0]         stall;
  } test_t;

  localparam test_t Tests [NrTests] = '{
    '{id: 3'd1, vl: 12'd100,  vd: 5'd3,  vm: 1'b1, stall: 8'd0},
    '{id: 3'd2, vl: 12'd300,  vd: 5'd7,  vm: 1'b0, stall: 8'd20},
    '{id: 3'd3, vl: 12'd1024, vd: 5'd12, vm: 1'b1, stall: 8'd30},
    '{id: 3'd4, vl: 12'd1024, vd: 5'd31, vm: 1'b0, stall: 8'd50},
    '{id: 3'd4, vl: 12'd129,  vd: 5'd0,  vm: 1'b0, stall: 8'd70},
    '{id: 3'd0, vl: 12'd1,    vd: 5'd5,  vm: 1'b1, stall: 8'd40}
  };

  logic                clk_i = 1'b0;
  logic                rst_ni;
  pe_req_t             pe_req_i;
  logic                pe_req_valid_i;
  logic                pe_req_ready_o;
  logic [NrVInsn-1:0]  pe_vinsn_running_i;
  pe_resp_t            pe_resp_o;
  elen_t [NrLanes-1:0] operand_a_i;
  logic [NrLanes-1:0]  operand_a_valid_i;
  logic [NrLanes-1:0]  operand_a_ready_o;
  elen_t [NrLanes-1:0] operand_b_i;
  logic [NrLanes-1:0]  operand_b_valid_i;
  logic [NrLanes-1:0]  operand_b_ready_o;
  elen_t [NrLanes-1:0] operand_m_i;
  logic [NrLanes-1:0]  operand_m_valid_i;
  logic [NrLanes-1:0]  operand_m_ready_o;
  logic [NrLanes-1:0]  result_req_o;
  vid_t [NrLanes-1:0]  result_id_o;
  vaddr_t [NrLanes-1:0] result_addr_o;
  elen_t [NrLanes-1:0] result_wdata_o;
  logic [NrLanes-1:0]  result_gnt_i;

  // Operands and reference results of the running row
  elen_t  a_mem   [MaxBeats][NrLanes];
  elen_t  b_mem   [MaxBeats][NrLanes];
  elen_t  m_mem   [MaxBeats][NrLanes];
  elen_t  exp_mem [MaxBeats][NrLanes];
  integer seed = 32'h6dee8190;
  int     errors = 0;
  string  test_name;

  always #(ClkHalf) clk_i = ~clk_i;

  masku_top #(
    .NrLanes          (NrLanes),
    .ResultQueueDepth (2)
  ) u_dut (.*);

  bind masku_top masku_props #(
    .NrLanes (NrLanes)
  ) u_props (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .pe_resp_o         (pe_resp_o),
    .operand_a_valid_i (operand_a_valid_i),
    .operand_a_ready_o (operand_a_ready_o),
    .operand_b_valid_i (operand_b_valid_i),
    .operand_b_ready_o (operand_b_ready_o),
    .operand_m_valid_i (operand_m_valid_i),
    .operand_m_ready_o (operand_m_ready_o),
    .result_req_o      (result_req_o),
    .result_id_o       (result_id_o),
    .result_addr_o     (result_addr_o),
    .result_wdata_o    (result_wdata_o),
    .result_gnt_i      (result_gnt_i)
  );

  ////////////////////////////////////////////////////////////
  // Reference model and helpers
  ////////////////////////////////////////////////////////////

  function automatic string test_label(int idx);
    case (idx)
      0: return "unmasked_tail";
      1: return "masked_tail";
      2: return "unmasked_full_reg";
      3: return "masked_full_reg";
      4: return "masked_reused_id";
      default: return "single_bit";
    endcase
  endfunction

  // Beats needed to cover vl bits
  function automatic int beats_of(vlen_t vl);
    return (int'(vl) + int'(BeatBits) - 1) / int'(BeatBits);
  endfunction

  function automatic int total_beats();
    int sum;
    sum = 0;
    for (int t = 0; t < NrTests; t++) begin
      sum += beats_of(Tests[t].vl);
    end
    return sum;
  endfunction

  function automatic elen_t random_word();
    return {$random(seed), $random(seed)};
  endfunction

  // Bit takes a below vl where unmasked or mask bit set and b elsewhere
  function automatic elen_t merge_ref(int beat, int lane, test_t tc,
                                      elen_t a, elen_t b, elen_t m);
    elen_t r;
    int    e;
    for (int i = 0; i < Elen; i++) begin
      e    = beat * int'(BeatBits) + lane * int'(Elen) + i;
      r[i] = (e < int'(tc.vl) && (tc.vm || m[i])) ? a[i] : b[i];
    end
    return r;
  endfunction

  task automatic report_failure(input string msg);
    errors++;
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1, "Stopped at first failure");
  endtask

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      report_failure($sformatf("MISMATCH %s %s expected %0h actual %0h",
                               test_name, what, expected, actual));
    end
  endtask

  // Lane model holds valid until the beat is consumed
  // Lanes that ran ahead keep the last words offered after the final beat
  task automatic drive_operands(input int ptr, input int nbeats, input logic vm);
    for (int l = 0; l < NrLanes; l++) begin
      if (ptr < nbeats) begin
        operand_a_i[l] = a_mem[ptr][l];
        operand_b_i[l] = b_mem[ptr][l];
        operand_m_i[l] = m_mem[ptr][l];
      end
    end
    operand_a_valid_i = '1;
    operand_b_valid_i = '1;
    // Mask lanes stay silent on unmasked rows
    operand_m_valid_i = {NrLanes{!vm}};
  endtask

  task automatic drive_grants(input int stall);
    int r;
    for (int l = 0; l < NrLanes; l++) begin
      r               = $random(seed);
      result_gnt_i[l] = ((r & 32'h7fff_ffff) % 100) >= stall;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // One table row
  ////////////////////////////////////////////////////////////

  task automatic run_test(input int t);
    test_t tc;
    int    nbeats;
    int    op_ptr;
    int    cycle;
    int    last_gnt;
    int    wb_cnt [NrLanes];
    logic  accepted;
    logic  done_seen;
    logic  fire;
    tc        = Tests[t];
    test_name = test_label(t);
    nbeats    = beats_of(tc.vl);
    for (int k = 0; k < nbeats; k++) begin
      for (int l = 0; l < NrLanes; l++) begin
        a_mem[k][l]   = random_word();
        b_mem[k][l]   = random_word();
        m_mem[k][l]   = random_word();
        exp_mem[k][l] = merge_ref(k, l, tc, a_mem[k][l], b_mem[k][l], m_mem[k][l]);
      end
    end
    for (int l = 0; l < NrLanes; l++) begin
      wb_cnt[l] = 0;
    end
    op_ptr    = 0;
    cycle     = 0;
    last_gnt  = 0;
    accepted  = 1'b0;
    done_seen = 1'b0;

    // Request goes out with beat 0 already offered
    @(posedge clk_i);
    #1;
    pe_req_i       = '{id: tc.id, vl: tc.vl, vd: tc.vd, vm: tc.vm};
    pe_req_valid_i = 1'b1;
    drive_operands(op_ptr, nbeats, tc.vm);
    while (!accepted) begin
      @(negedge clk_i);
      check_value("operand ready before accept", '0, 64'(operand_a_ready_o));
      accepted = pe_req_ready_o;
      @(posedge clk_i);
      #1;
    end
    pe_req_valid_i            = 1'b0;
    pe_vinsn_running_i[tc.id] = 1'b1;

    // Drive after the rising edge and sample at the falling edge
    while (!done_seen) begin
      drive_operands(op_ptr, nbeats, tc.vm);
      drive_grants(int'(tc.stall));
      @(negedge clk_i);
      cycle++;
      check_value("pe_req_ready_o while held", '0, 64'(pe_req_ready_o));
      // All lanes consume one beat together
      fire = operand_a_ready_o[0];
      check_value("a ready", 64'({NrLanes{fire}}), 64'(operand_a_ready_o));
      check_value("b ready", 64'({NrLanes{fire}}), 64'(operand_b_ready_o));
      check_value("m ready", 64'({NrLanes{fire && !tc.vm}}), 64'(operand_m_ready_o));
      if (fire) begin
        if (op_ptr >= nbeats) begin
          report_failure($sformatf("Operands consumed past the final beat in %s",
                                   test_name));
        end
        op_ptr++;
      end
      // Writes arrive in beat order and once each
      for (int l = 0; l < NrLanes; l++) begin
        if (result_req_o[l]) begin
          if (wb_cnt[l] >= nbeats) begin
            report_failure($sformatf("Extra write-back on lane %0d in test %s", l, test_name));
          end else begin
            check_value($sformatf("lane %0d beat %0d addr", l, wb_cnt[l]),
                        64'(int'(tc.vd) * int'(MaxBeats) + wb_cnt[l]), 64'(result_addr_o[l]));
            check_value($sformatf("lane %0d beat %0d id", l, wb_cnt[l]),
                        64'(tc.id), 64'(result_id_o[l]));
            check_value($sformatf("lane %0d beat %0d wdata", l, wb_cnt[l]),
                        exp_mem[wb_cnt[l]][l], result_wdata_o[l]);
            if (result_gnt_i[l]) begin
              wb_cnt[l]++;
              last_gnt = cycle;
            end
          end
        end
      end
      if (pe_resp_o != '0) begin
        check_value("done vector", 64'(1) << tc.id, 64'(pe_resp_o));
        check_value("beats consumed", 64'(nbeats), 64'(op_ptr));
        for (int l = 0; l < NrLanes; l++) begin
          check_value($sformatf("lane %0d beats written", l), 64'(nbeats), 64'(wb_cnt[l]));
        end
        check_value("cycles from last gnt to done", 64'(2), 64'(cycle - last_gnt));
        done_seen = 1'b1;
      end
      @(posedge clk_i);
      #1;
    end

    // Slot stays closed while the id is still marked running
    result_gnt_i = '0;
    drive_operands(nbeats, nbeats, tc.vm);
    repeat (3) begin
      @(negedge clk_i);
      check_value("second done pulse", '0, 64'(pe_resp_o));
      check_value("req after final beat", '0, 64'(result_req_o));
      check_value("pe_req_ready_o with id running", '0, 64'(pe_req_ready_o));
      check_value("operand ready with slot empty", '0,
                  64'({operand_a_ready_o, operand_b_ready_o, operand_m_ready_o}));
      @(posedge clk_i);
      #1;
    end
    pe_vinsn_running_i[tc.id] = 1'b0;
    @(negedge clk_i);
    check_value("pe_req_ready_o before running clears", '0, 64'(pe_req_ready_o));
    @(negedge clk_i);
    check_value("pe_req_ready_o after release", 64'(1), 64'(pe_req_ready_o));
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    test_name          = "reset";
    rst_ni             = 1'b0;
    pe_req_i           = '0;
    pe_req_valid_i     = 1'b0;
    pe_vinsn_running_i = '0;
    operand_a_i        = '0;
    operand_b_i        = '0;
    operand_m_i        = '0;
    operand_a_valid_i  = '0;
    operand_b_valid_i  = '0;
    operand_m_valid_i  = '0;
    result_gnt_i       = '0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("pe_req_ready_o after reset", 64'(1), 64'(pe_req_ready_o));
    check_value("result_req_o after reset", '0, 64'(result_req_o));
    check_value("pe_resp_o after reset", '0, 64'(pe_resp_o));
    check_value("operand readies after reset", '0,
                64'({operand_a_ready_o, operand_b_ready_o, operand_m_ready_o}));
    for (int t = 0; t < NrTests; t++) begin
      run_test(t);
    end
    if (errors == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      report_failure("Error count is not zero at the end of the run");
    end
  end

  // Budget of 40 cycles per beat plus setup
  initial begin
    int unsigned limit;
    limit = total_beats() * 40 + 200;
    repeat (limit) @(posedge clk_i);
    report_failure($sformatf("Timeout after %0d cycles, the table did not finish", limit));
  end

endmodule

`default_nettype wire

/* verif/masku_props.sv */
////////////////////////////////////////////////////////////
// Mask unit port properties, bound to the top level
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module masku_props #(
  parameter int unsigned NrLanes = 2
) (
  input logic                                   clk_i,
  input logic                                   rst_ni,
  input masku_seq_pkg::pe_resp_t                pe_resp_o,
  input logic [NrLanes-1:0]                     operand_a_valid_i,
  input logic [NrLanes-1:0]                     operand_a_ready_o,
  input logic [NrLanes-1:0]                     operand_b_valid_i,
  input logic [NrLanes-1:0]                     operand_b_ready_o,
  input logic [NrLanes-1:0]                     operand_m_valid_i,
  input logic [NrLanes-1:0]                     operand_m_ready_o,
  input logic [NrLanes-1:0]                     result_req_o,
  input masku_cfg_pkg::vid_t [NrLanes-1:0]      result_id_o,
  input masku_cfg_pkg::vaddr_t [NrLanes-1:0]    result_addr_o,
  input masku_cfg_pkg::elen_t [NrLanes-1:0]     result_wdata_o,
  input logic [NrLanes-1:0]                     result_gnt_i
);

  // Waiting write keeps req and payload until gnt
  for (genvar l = 0; l < NrLanes; l++) begin : gen_lane
    req_holds: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (result_req_o[l] && !result_gnt_i[l]) |=>
        (result_req_o[l] && $stable(result_id_o[l]) && $stable(result_addr_o[l]) &&
         $stable(result_wdata_o[l])))
      else $error("Lane %0d dropped or changed its write before gnt", l);
  end

  // At most one id completes per cycle
  done_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(pe_resp_o.vinsn_done))
    else $error("More than one done bit in the same cycle");

  // Consumption only on lanes that offer data
  ready_has_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((operand_a_ready_o & ~operand_a_valid_i) == '0) &&
    ((operand_b_ready_o & ~operand_b_valid_i) == '0) &&
    ((operand_m_ready_o & ~operand_m_valid_i) == '0))
    else $error("Operand ready high on a lane without valid");

endmodule

`default_nettype wire

/* src/masku_top.sv */
////////////////////////////////////////////////////////////
// Mask unit top level
// Merges lane results under vl and mask into the VRF
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module masku_top #(
  parameter int unsigned NrLanes          = 2,
  parameter int unsigned ResultQueueDepth = 2
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // Sequencer
  input  masku_seq_pkg::pe_req_t                 pe_req_i,
  input  logic                                   pe_req_valid_i,
  output logic                                   pe_req_ready_o,
  input  logic [masku_cfg_pkg::NrVInsn-1:0]      pe_vinsn_running_i,
  output masku_seq_pkg::pe_resp_t                pe_resp_o,
  // Operand a
  input  masku_cfg_pkg::elen_t [NrLanes-1:0]     operand_a_i,
  input  logic [NrLanes-1:0]                     operand_a_valid_i,
  output logic [NrLanes-1:0]                     operand_a_ready_o,
  // Operand b
  input  masku_cfg_pkg::elen_t [NrLanes-1:0]     operand_b_i,
  input  logic [NrLanes-1:0]                     operand_b_valid_i,
  output logic [NrLanes-1:0]                     operand_b_ready_o,
  // Operand m
  input  masku_cfg_pkg::elen_t [NrLanes-1:0]     operand_m_i,
  input  logic [NrLanes-1:0]                     operand_m_valid_i,
  output logic [NrLanes-1:0]                     operand_m_ready_o,
  // Lane write-back
  output logic [NrLanes-1:0]                     result_req_o,
  output masku_cfg_pkg::vid_t [NrLanes-1:0]      result_id_o,
  output masku_cfg_pkg::vaddr_t [NrLanes-1:0]    result_addr_o,
  output masku_cfg_pkg::elen_t [NrLanes-1:0]     result_wdata_o,
  input  logic [NrLanes-1:0]                     result_gnt_i
);
  import masku_seq_pkg::*;

  pe_req_t insn;
  logic    insn_valid;
  logic    issue_done;
  logic    beat_retired;

  masku_result_if #(.NrLanes(NrLanes)) u_res_if ();

  masku_insn_queue #(
    .NrLanes (NrLanes)
  ) u_insn_queue (
    .clk_i,
    .rst_ni,
    .pe_req_i,
    .pe_req_valid_i,
    .pe_vinsn_running_i,
    .pe_req_ready_o,
    .insn_o         (insn),
    .insn_valid_o   (insn_valid),
    .issue_done_i   (issue_done),
    .beat_retired_i (beat_retired),
    .pe_resp_o
  );

  masku_issue #(
    .NrLanes (NrLanes)
  ) u_issue (
    .clk_i,
    .rst_ni,
    .insn_i       (insn),
    .insn_valid_i (insn_valid),
    .operand_a_i,
    .operand_a_valid_i,
    .operand_a_ready_o,
    .operand_b_i,
    .operand_b_valid_i,
    .operand_b_ready_o,
    .operand_m_i,
    .operand_m_valid_i,
    .operand_m_ready_o,
    .issue_done_o (issue_done),
    .res          (u_res_if.issue)
  );

  masku_result_queue #(
    .NrLanes          (NrLanes),
    .ResultQueueDepth (ResultQueueDepth)
  ) u_result_queue (
    .clk_i,
    .rst_ni,
    .res            (u_res_if.queue),
    .result_req_o,
    .result_id_o,
    .result_addr_o,
    .result_wdata_o,
    .result_gnt_i,
    .beat_retired_o (beat_retired)
  );

endmodule

`default_nettype wire

/* src/masku_result_queue.sv */
////////////////////////////////////////////////////////////
// Mask unit result queue
// Buffers merged beats and writes them back per lane
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module masku_result_queue #(
  parameter int unsigned NrLanes          = 2,
  parameter int unsigned ResultQueueDepth = 2
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  masku_result_if.queue                          res,
  // Register-file write ports, one per lane
  output logic [NrLanes-1:0]                     result_req_o,
  output masku_cfg_pkg::vid_t [NrLanes-1:0]      result_id_o,
  output masku_cfg_pkg::vaddr_t [NrLanes-1:0]    result_addr_o,
  output masku_cfg_pkg::elen_t [NrLanes-1:0]     result_wdata_o,
  input  logic [NrLanes-1:0]                     result_gnt_i,
  output logic                                   beat_retired_o
);
  import masku_cfg_pkg::*;

  localparam int unsigned PtrWidth = (ResultQueueDepth > 1) ? $clog2(ResultQueueDepth) : 1;
  localparam int unsigned CntWidth = $clog2(ResultQueueDepth + 1);

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  elen_t [ResultQueueDepth-1:0][NrLanes-1:0] wdata_q;
  vaddr_t [ResultQueueDepth-1:0]             addr_q;
  vid_t [ResultQueueDepth-1:0]               id_q;
  // Lanes still waiting for their grant
  logic [ResultQueueDepth-1:0][NrLanes-1:0]  pending_q;
  logic [PtrWidth-1:0]                       wr_ptr_q;
  logic [PtrWidth-1:0]                       rd_ptr_q;
  logic [CntWidth-1:0]                       cnt_q;
  logic                                      push;
  logic                                      pop;

  function automatic logic [PtrWidth-1:0] next_ptr(logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(ResultQueueDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Full queue stalls the issue stage
  assign res.ready = (cnt_q != CntWidth'(ResultQueueDepth));
  assign push      = res.valid && res.ready;

  // Head retires once every lane has been granted
  assign pop            = (cnt_q != '0) && (pending_q[rd_ptr_q] == '0);
  assign beat_retired_o = pop;

  ////////////////////////////////////////////////////////////
  // Write-back
  ////////////////////////////////////////////////////////////

  // Free entries never hold pending bits
  for (genvar lane = 0; lane < NrLanes; lane++) begin : gen_lane
    assign result_req_o[lane]   = pending_q[rd_ptr_q][lane];
    assign result_id_o[lane]    = id_q[rd_ptr_q];
    assign result_addr_o[lane]  = addr_q[rd_ptr_q];
    assign result_wdata_o[lane] = wdata_q[rd_ptr_q][lane];
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= '0;
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      cnt_q     <= '0;
    end else begin
      // Granted lanes drop their request
      for (int lane = 0; lane < NrLanes; lane++) begin
        if (result_req_o[lane] && result_gnt_i[lane]) begin
          pending_q[rd_ptr_q][lane] <= 1'b0;
        end
      end
      // New entry requests on all lanes
      if (push) begin
        pending_q[wr_ptr_q] <= '1;
        wr_ptr_q            <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      cnt_q <= cnt_q + CntWidth'(push) - CntWidth'(pop);
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (push) begin
      wdata_q[wr_ptr_q] <= res.wdata;
      addr_q[wr_ptr_q]  <= res.addr;
      id_q[wr_ptr_q]    <= res.id;
    end
  end

endmodule

`default_nettype wire

/* src/masku_issue.sv */
////////////////////////////////////////////////////////////
// Mask unit issue stage
// Beat sequencing, operand handshakes, result payload
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module masku_issue #(
  parameter int unsigned NrLanes = 2
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // Held instruction
  input  masku_seq_pkg::pe_req_t                 insn_i,
  input  logic                                   insn_valid_i,
  // Operand a, lane ALU result
  input  masku_cfg_pkg::elen_t [NrLanes-1:0]     operand_a_i,
  input  logic [NrLanes-1:0]                     operand_a_valid_i,
  output logic [NrLanes-1:0]                     operand_a_ready_o,
  // Operand b, old destination value
  input  masku_cfg_pkg::elen_t [NrLanes-1:0]     operand_b_i,
  input  logic [NrLanes-1:0]                     operand_b_valid_i,
  output logic [NrLanes-1:0]                     operand_b_ready_o,
  // Operand m, mask
  input  masku_cfg_pkg::elen_t [NrLanes-1:0]     operand_m_i,
  input  logic [NrLanes-1:0]                     operand_m_valid_i,
  output logic [NrLanes-1:0]                     operand_m_ready_o,
  output logic                                   issue_done_o,
  masku_result_if.issue                          res
);
  import masku_cfg_pkg::*;

  localparam int unsigned BeatBits = NrLanes * Elen;

  logic [BeatWidth-1:0] beat_q;
  // Final beat sent, wait for the next instruction
  logic                 issued_q;
  logic                 operands_valid;
  logic                 fire;
  logic                 last_beat;
  logic [VlenWidth:0]   next_first;

  // Mask lanes only matter for masked instructions
  assign operands_valid = (&operand_a_valid_i) && (&operand_b_valid_i) &&
                          (insn_i.vm || (&operand_m_valid_i));

  assign res.valid = insn_valid_i && !issued_q && operands_valid;
  assign fire      = res.valid && res.ready;

  // Beat is the last one once the next beat would start at or past vl
  assign next_first = (VlenWidth+1)'(beat_q) * (VlenWidth+1)'(BeatBits) +
                      (VlenWidth+1)'(BeatBits);
  assign last_beat    = next_first >= {1'b0, insn_i.vl};
  assign issue_done_o = fire && last_beat;

  // Consume all lanes together
  assign operand_a_ready_o = {NrLanes{fire}};
  assign operand_b_ready_o = {NrLanes{fire}};
  assign operand_m_ready_o = {NrLanes{fire && !insn_i.vm}};

  // Payload fields
  assign res.addr = {insn_i.vd, beat_q};
  assign res.id   = insn_i.id;

  masku_alu #(
    .NrLanes (NrLanes)
  ) u_alu (
    .beat_i   (beat_q),
    .vl_i     (insn_i.vl),
    .vm_i     (insn_i.vm),
    .a_i      (operand_a_i),
    .b_i      (operand_b_i),
    .m_i      (operand_m_i),
    .result_o (res.wdata)
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_q   <= '0;
      issued_q <= 1'b0;
    end else begin
      if (fire) begin
        beat_q <= last_beat ? '0 : beat_q + 1'b1;
      end
      // Slot empties between instructions, which rearms issue
      if (issue_done_o) begin
        issued_q <= 1'b1;
      end else if (!insn_valid_i) begin
        issued_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* src/masku_alu.sv */
////////////////////////////////////////////////////////////
// Mask merge ALU
// Tail enable from vl, optional mask, bitwise a/b select
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module masku_alu #(
  parameter int unsigned NrLanes = 2
) (
  input  logic [masku_cfg_pkg::BeatWidth-1:0]    beat_i,
  input  masku_cfg_pkg::vlen_t                   vl_i,
  input  logic                                   vm_i,
  input  masku_cfg_pkg::elen_t [NrLanes-1:0]     a_i,
  input  masku_cfg_pkg::elen_t [NrLanes-1:0]     b_i,
  input  masku_cfg_pkg::elen_t [NrLanes-1:0]     m_i,
  output masku_cfg_pkg::elen_t [NrLanes-1:0]     result_o
);
  import masku_cfg_pkg::*;

  localparam int unsigned BeatBits = NrLanes * Elen;

  // Element index of bit 0 of lane 0 in this beat
  logic [VlenWidth:0]  first_elem;
  logic [VlenWidth:0]  remaining;
  logic [BeatBits-1:0] tail_en;
  logic [BeatBits-1:0] bit_en;

  assign first_elem = (VlenWidth+1)'(beat_i) * (VlenWidth+1)'(BeatBits);
  assign remaining  = {1'b0, vl_i} - first_elem;

  // Bits below vl are body, the rest is tail
  always_comb begin
    if ({1'b0, vl_i} <= first_elem) begin
      tail_en = '0;
    end else if (remaining >= BeatBits) begin
      tail_en = '1;
    end else begin
      tail_en = (BeatBits'(1) << remaining) - 1'b1;
    end
  end

  // Lanes hold consecutive bits, so the flat view lines up with m
  assign bit_en = vm_i ? tail_en : (tail_en & m_i);

  // New value where enabled, old destination elsewhere
  assign result_o = (a_i & bit_en) | (b_i & ~bit_en);

endmodule

`default_nettype wire

/* src/masku_insn_queue.sv */
////////////////////////////////////////////////////////////
// Mask unit instruction slot
// Accepts requests, counts committed beats, reports done
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module masku_insn_queue #(
  parameter int unsigned NrLanes = 2
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // Sequencer side
  input  masku_seq_pkg::pe_req_t                 pe_req_i,
  input  logic                                   pe_req_valid_i,
  input  logic [masku_cfg_pkg::NrVInsn-1:0]      pe_vinsn_running_i,
  output logic                                   pe_req_ready_o,
  // Held instruction toward the issue stage
  output masku_seq_pkg::pe_req_t                 insn_o,
  output logic                                   insn_valid_o,
  // Progress from issue stage and result queue
  input  logic                                   issue_done_i,
  input  logic                                   beat_retired_i,
  output masku_seq_pkg::pe_resp_t                pe_resp_o
);
  import masku_cfg_pkg::*;
  import masku_seq_pkg::*;

  localparam int unsigned BeatBits = NrLanes * Elen;
  localparam int unsigned CntWidth = $clog2(MaxBeats + 1);

  pe_req_t             insn_q;
  logic                valid_q;
  // All beats of the held instruction have been issued
  logic                issued_q;
  logic [NrVInsn-1:0]  running_q;
  // Beats still waiting for write-back
  logic [CntWidth-1:0] commit_cnt_q;
  logic [CntWidth-1:0] nr_beats;
  logic [VlenWidth:0]  vl_round;
  logic                accept;
  logic                commit_done;

  // Single slot, and no reuse of an id the sequencer still tracks
  assign pe_req_ready_o = !valid_q && !running_q[pe_req_i.id];
  assign accept         = pe_req_valid_i && pe_req_ready_o;

  // Beat count is ceil(vl / beat width)
  assign vl_round = {1'b0, pe_req_i.vl} + (VlenWidth+1)'(BeatBits - 1);
  assign nr_beats = CntWidth'(vl_round / BeatBits);

  // Last outstanding beat retires
  assign commit_done = valid_q && issued_q && beat_retired_i &&
                       (commit_cnt_q == CntWidth'(1));

  assign insn_o       = insn_q;
  assign insn_valid_o = valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q      <= 1'b0;
      issued_q     <= 1'b0;
      running_q    <= '0;
      commit_cnt_q <= '0;
      pe_resp_o    <= '0;
    end else begin
      // Sequencer drops ids once it is done with them
      running_q <= running_q & pe_vinsn_running_i;
      pe_resp_o <= '0;
      if (accept) begin
        valid_q                  <= 1'b1;
        issued_q                 <= 1'b0;
        commit_cnt_q             <= nr_beats;
        running_q[pe_req_i.id]   <= 1'b1;
      end else begin
        if (issue_done_i) begin
          issued_q <= 1'b1;
        end
        if (beat_retired_i && valid_q) begin
          commit_cnt_q <= commit_cnt_q - 1'b1;
        end
        // Free the slot and report the id
        if (commit_done) begin
          valid_q                          <= 1'b0;
          pe_resp_o.vinsn_done[insn_q.id]  <= 1'b1;
        end
      end
    end
  end

  // Instruction fields
  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q <= pe_req_i;
    end
  end

endmodule

`default_nettype wire

/* src/masku_result_if.sv */
////////////////////////////////////////////////////////////
// Result beat link from issue stage to result queue
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

interface masku_result_if #(
  parameter int unsigned NrLanes = 2
);
  import masku_cfg_pkg::*;

  // Beat offered, independent of ready
  logic valid;
  // Queue has a free entry
  logic ready;

  // Merged word per lane
  elen_t [NrLanes-1:0] wdata;
  // Same address and id go to every lane
  vaddr_t addr;
  vid_t id;

  // Producer side
  modport issue (output valid, wdata, addr, id, input ready);

  // Consumer side
  modport queue (input valid, wdata, addr, id, output ready);

endinterface

`default_nettype wire

/* src/masku_seq_pkg.sv */
////////////////////////////////////////////////////////////
// Sequencer interface formats
// Request and response seen by the mask unit
////////////////////////////////////////////////////////////
`default_nettype none

package masku_seq_pkg;

  // One mask-logical merge instruction
  typedef struct packed {
    // Instruction id, also tags every write-back
    masku_cfg_pkg::vid_t id;
    // Vector length in bits, at least one
    masku_cfg_pkg::vlen_t vl;
    // Destination vector register
    logic [masku_cfg_pkg::VdWidth-1:0] vd;
    // Set when the instruction is unmasked
    logic vm;
  } pe_req_t;

  // Completion report back to the sequencer
  typedef struct packed {
    // One bit per id, pulsed for a single cycle
    logic [masku_cfg_pkg::NrVInsn-1:0] vinsn_done;
  } pe_resp_t;

endpackage

`default_nettype wire

/* src/masku_cfg_pkg.sv */
////////////////////////////////////////////////////////////
// Mask unit configuration
// Datapath sizes and the data, id, length and address types
////////////////////////////////////////////////////////////
`default_nettype none

package masku_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  // Bits per lane per beat, one register-file word
  localparam int unsigned Elen = 64;
  // Beats in one vector register
  localparam int unsigned MaxBeats = 8;
  // Instruction ids known to the sequencer
  localparam int unsigned NrVInsn = 8;

  // Vector length field, enough for 8 beats of 4 lanes
  localparam int unsigned VlenWidth = 12;
  // Destination register index
  localparam int unsigned VdWidth = 5;
  // Beat number inside one vector register
  localparam int unsigned BeatWidth = $clog2(MaxBeats);

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  typedef logic [Elen-1:0] elen_t;
  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  typedef logic [VlenWidth-1:0] vlen_t;
  // Word address, vd on top and beat number below
  typedef logic [VdWidth+BeatWidth-1:0] vaddr_t;

endpackage

`default_nettype wire
